// File: design/kbd_settings.svh
`ifndef KBD_SETTINGS_SVH
`define KBD_SETTINGS_SVH

// event FIFO entries, a power of two
`define KBD_FIFO_DEPTH 8

// register map
`define KBD_ADDR_CTRL   2'd0
`define KBD_ADDR_STATUS 2'd1
`define KBD_ADDR_DATA   2'd2
`define KBD_ADDR_ERRCNT 2'd3

// saturating frame error counter
`define KBD_ERRCNT_WIDTH 8

`endif

// File: design/ps2_pkg.sv
package ps2_pkg;

    // one byte as carried by a PS/2 frame
    typedef logic [7:0] byte_t;

    // index of the data bit being shifted in
    typedef logic [2:0] bit_cnt_t;

    // receiver frame states
    // the start bit is taken in IDLE, the eight data bits in DATA
    typedef enum logic [1:0] {
        IDLE   = 2'b00,
        DATA   = 2'b01,
        PARITY = 2'b10,
        STOP   = 2'b11
    } ps2_state_t;

endpackage

// File: design/kbd_pkg.sv
package kbd_pkg;

    // final scancode byte of a key, set 2
    typedef logic [7:0] keycode_t;

    // key event word
    // bit 9 released, bit 8 extended, bits 7:0 keycode
    typedef logic [9:0] key_event_t;

    // register port
    typedef logic [1:0]  reg_addr_t;
    typedef logic [15:0] reg_data_t;

    // prefix tracking in the scancode decoder
    typedef enum logic [1:0] {
        NORMAL   = 2'b00,
        GOT_E0   = 2'b01,
        GOT_F0   = 2'b10,
        GOT_E0F0 = 2'b11
    } dec_state_t;

endpackage

// File: design/ps2_rx.sv
`timescale 1ns/10ps

module ps2_rx
    import ps2_pkg::*;
(
    input  logic  clk_i,
    input  logic  reset_i,
    input  logic  ps2_clk_async_i,
    input  logic  ps2_data_async_i,
    output byte_t data_o,
    output logic  valid_o,
    output logic  error_o
);

    // two-flop synchronizers, the clock gets one more flop for edge history
    logic [2:0] clk_sync_r;
    logic [1:0] data_sync_r;
    logic       fall_r;
    logic       ps2_data;

    ps2_state_t state_r;
    bit_cnt_t   bit_cnt_r;
    byte_t      shift_r;
    logic       parity_r;

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            clk_sync_r  <= 3'b111;
            data_sync_r <= 2'b11;
            fall_r      <= 1'b0;
        end else begin
            clk_sync_r  <= {clk_sync_r[1:0], ps2_clk_async_i};
            data_sync_r <= {data_sync_r[0], ps2_data_async_i};
            // registered falling edge strobe
            fall_r      <= clk_sync_r[2] && !clk_sync_r[1];
        end
    end

    // data line is stable around the falling edge
    assign ps2_data = data_sync_r[1];

    // frame FSM
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            state_r   <= IDLE;
            bit_cnt_r <= '0;
            parity_r  <= 1'b0;
            valid_o   <= 1'b0;
            error_o   <= 1'b0;
        end else begin
            valid_o <= 1'b0;
            error_o <= 1'b0;
            if (fall_r) begin
                case (state_r)
                    IDLE: begin
                        // start bit must be low
                        if (!ps2_data) begin
                            state_r   <= DATA;
                            bit_cnt_r <= '0;
                            parity_r  <= 1'b0;
                        end
                    end
                    DATA: begin
                        parity_r  <= parity_r ^ ps2_data;
                        bit_cnt_r <= bit_cnt_r + 1'b1;
                        if (bit_cnt_r == '1) begin
                            state_r <= PARITY;
                        end
                    end
                    PARITY: begin
                        // odd parity over data bits and parity bit
                        if (parity_r ^ ps2_data) begin
                            state_r <= STOP;
                        end else begin
                            error_o <= 1'b1;
                            state_r <= IDLE;
                        end
                    end
                    STOP: begin
                        state_r <= IDLE;
                        if (ps2_data) begin
                            valid_o <= 1'b1;
                        end else begin
                            error_o <= 1'b1;
                        end
                    end
                    default: begin
                        state_r <= IDLE;
                    end
                endcase
            end
        end
    end

    // LSB arrives first, so shift in from the top
    always_ff @(posedge clk_i) begin
        if (fall_r && (state_r == DATA)) begin
            shift_r <= {ps2_data, shift_r[7:1]};
        end
    end

    // shift register holds the byte until the next frame's data bits
    assign data_o = shift_r;

    // a frame ends either good or bad, never both
    a_valid_error_excl: assert property (
        @(posedge clk_i) disable iff (reset_i)
        !(valid_o && error_o)
    );

endmodule

// File: design/scancode_decoder.sv
`timescale 1ns/10ps

module scancode_decoder
    import ps2_pkg::*;
    import kbd_pkg::*;
(
    input  logic       clk_i,
    input  logic       reset_i,
    input  logic       enable_i,
    input  byte_t      byte_i,
    input  logic       byte_valid_i,
    output key_event_t event_o,
    output logic       event_valid_o
);

    // set 2 prefix bytes
    localparam byte_t PREFIX_EXT   = 8'hE0;
    localparam byte_t PREFIX_BREAK = 8'hF0;

    dec_state_t state_r;
    logic       released;
    logic       extended;
    logic       take_byte;

    assign take_byte = enable_i && byte_valid_i;

    // flags collected so far
    assign released = (state_r == GOT_F0) || (state_r == GOT_E0F0);
    assign extended = (state_r == GOT_E0) || (state_r == GOT_E0F0);

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            state_r       <= NORMAL;
            event_valid_o <= 1'b0;
        end else begin
            event_valid_o <= 1'b0;
            if (!enable_i) begin
                state_r <= NORMAL;
            end else if (take_byte) begin
                if (byte_i == PREFIX_EXT) begin
                    // E0 adds the extended flag
                    if (state_r == GOT_F0) begin
                        state_r <= GOT_E0F0;
                    end else if (state_r == NORMAL) begin
                        state_r <= GOT_E0;
                    end
                end else if (byte_i == PREFIX_BREAK) begin
                    // F0 adds the released flag
                    if (state_r == GOT_E0) begin
                        state_r <= GOT_E0F0;
                    end else if (state_r == NORMAL) begin
                        state_r <= GOT_F0;
                    end
                end else begin
                    // final byte closes the sequence
                    event_valid_o <= 1'b1;
                    state_r       <= NORMAL;
                end
            end
        end
    end

    // event payload
    always_ff @(posedge clk_i) begin
        if (take_byte && (byte_i != PREFIX_EXT) && (byte_i != PREFIX_BREAK)) begin
            event_o <= {released, extended, keycode_t'(byte_i)};
        end
    end

    // events come only from a byte one cycle earlier
    a_event_after_byte: assert property (
        @(posedge clk_i) disable iff (reset_i)
        event_valid_o |-> $past(byte_valid_i)
    );

endmodule

// File: design/key_fifo.sv
`timescale 1ns/10ps
`include "kbd_settings.svh"

module key_fifo
    import kbd_pkg::*;
(
    input  logic       clk_i,
    input  logic       reset_i,
    input  logic       push_i,
    input  key_event_t push_data_i,
    input  logic       pop_i,
    output key_event_t head_o,
    output logic       empty_o,
    output logic       overflow_o
);

    localparam int DEPTH = `KBD_FIFO_DEPTH;
    localparam int PTR_W = $clog2(DEPTH);

    key_event_t       mem [DEPTH];
    logic [PTR_W-1:0] rd_ptr_r;
    logic [PTR_W-1:0] wr_ptr_r;
    logic [PTR_W:0]   count_r;
    logic             full;
    logic             do_pop;
    logic             do_push;

    assign empty_o = (count_r == '0);
    assign full    = (count_r == DEPTH[PTR_W:0]);
    assign do_pop  = pop_i && !empty_o;
    // a pop in the same cycle frees a slot
    assign do_push = push_i && (!full || do_pop);

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            rd_ptr_r   <= '0;
            wr_ptr_r   <= '0;
            count_r    <= '0;
            overflow_o <= 1'b0;
        end else begin
            overflow_o <= push_i && !do_push;
            if (do_push) begin
                wr_ptr_r <= wr_ptr_r + 1'b1;
            end
            if (do_pop) begin
                rd_ptr_r <= rd_ptr_r + 1'b1;
            end
            count_r <= count_r + (PTR_W+1)'(do_push) - (PTR_W+1)'(do_pop);
        end
    end

    always_ff @(posedge clk_i) begin
        if (do_push) begin
            mem[wr_ptr_r] <= push_data_i;
        end
    end

    assign head_o = mem[rd_ptr_r];

    a_count_bound: assert property (
        @(posedge clk_i) disable iff (reset_i)
        count_r <= DEPTH
    );

endmodule

// File: design/kbd_regs.sv
`timescale 1ns/10ps
`include "kbd_settings.svh"

module kbd_regs
    import kbd_pkg::*;
(
    input  logic       clk_i,
    input  logic       reset_i,
    input  logic       sel_i,
    input  logic       we_i,
    input  reg_addr_t  addr_i,
    input  reg_data_t  wdata_i,
    output reg_data_t  rdata_o,
    input  key_event_t fifo_head_i,
    input  logic       fifo_empty_i,
    input  logic       fifo_overflow_i,
    input  logic       rx_error_i,
    output logic       fifo_pop_o,
    output logic       enable_o,
    output logic       irq_o
);

    localparam int ERR_W = `KBD_ERRCNT_WIDTH;
    localparam int EV_W  = $bits(key_event_t);

    logic             ctrl_enable_r;
    logic             ctrl_irq_en_r;
    logic             overflow_r;
    logic             frame_error_r;
    logic [ERR_W-1:0] errcnt_r;
    logic             wr;
    logic             rd;

    assign wr = sel_i && we_i;
    assign rd = sel_i && !we_i;

    // reading DATA consumes the head entry
    assign fifo_pop_o = rd && (addr_i == `KBD_ADDR_DATA) && !fifo_empty_i;

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            ctrl_enable_r <= 1'b0;
            ctrl_irq_en_r <= 1'b0;
            overflow_r    <= 1'b0;
            frame_error_r <= 1'b0;
            errcnt_r      <= '0;
            irq_o         <= 1'b0;
        end else begin
            if (wr && (addr_i == `KBD_ADDR_CTRL)) begin
                ctrl_enable_r <= wdata_i[0];
                ctrl_irq_en_r <= wdata_i[1];
            end
            // a new event wins over write-1-to-clear on sticky bits
            if (fifo_overflow_i) begin
                overflow_r <= 1'b1;
            end else if (wr && (addr_i == `KBD_ADDR_STATUS) && wdata_i[1]) begin
                overflow_r <= 1'b0;
            end
            if (rx_error_i) begin
                frame_error_r <= 1'b1;
            end else if (wr && (addr_i == `KBD_ADDR_STATUS) && wdata_i[2]) begin
                frame_error_r <= 1'b0;
            end
            // saturating error count
            if (wr && (addr_i == `KBD_ADDR_ERRCNT)) begin
                errcnt_r <= '0;
            end else if (rx_error_i && (errcnt_r != '1)) begin
                errcnt_r <= errcnt_r + 1'b1;
            end
            irq_o <= ctrl_irq_en_r && !fifo_empty_i;
        end
    end

    assign enable_o = ctrl_enable_r;

    always_comb begin
        rdata_o = '0;
        case (addr_i)
            `KBD_ADDR_CTRL:   rdata_o[1:0] = {ctrl_irq_en_r, ctrl_enable_r};
            `KBD_ADDR_STATUS: rdata_o[2:0] = {frame_error_r, overflow_r, !fifo_empty_i};
            `KBD_ADDR_DATA: begin
                if (!fifo_empty_i) begin
                    rdata_o[EV_W-1:0] = fifo_head_i;
                end
            end
            default:          rdata_o[ERR_W-1:0] = errcnt_r;
        endcase
    end

    // the FIFO flags overflow only while it holds entries
    a_overflow_not_empty: assert property (
        @(posedge clk_i) disable iff (reset_i)
        fifo_overflow_i |-> !fifo_empty_i
    );

endmodule

// File: design/kbd_top.sv
`timescale 1ns/10ps

module kbd_top (
    input  logic               clk_i,
    input  logic               reset_i,
    input  logic               ps2_clk_i,
    input  logic               ps2_data_i,
    input  logic               sel_i,
    input  logic               we_i,
    input  kbd_pkg::reg_addr_t addr_i,
    input  kbd_pkg::reg_data_t wdata_i,
    output kbd_pkg::reg_data_t rdata_o,
    output logic               irq_o
);

    ps2_pkg::byte_t      rx_byte;
    logic                rx_valid;
    logic                rx_error;
    kbd_pkg::key_event_t ev_data;
    logic                ev_valid;
    kbd_pkg::key_event_t fifo_head;
    logic                fifo_empty;
    logic                fifo_overflow;
    logic                fifo_pop;
    logic                ctrl_enable;

    ps2_rx rx0 (
        .clk_i            (clk_i),
        .reset_i          (reset_i),
        .ps2_clk_async_i  (ps2_clk_i),
        .ps2_data_async_i (ps2_data_i),
        .data_o           (rx_byte),
        .valid_o          (rx_valid),
        .error_o          (rx_error)
    );

    scancode_decoder dec0 (
        .clk_i         (clk_i),
        .reset_i       (reset_i),
        .enable_i      (ctrl_enable),
        .byte_i        (rx_byte),
        .byte_valid_i  (rx_valid),
        .event_o       (ev_data),
        .event_valid_o (ev_valid)
    );

    key_fifo fifo0 (
        .clk_i       (clk_i),
        .reset_i     (reset_i),
        .push_i      (ev_valid),
        .push_data_i (ev_data),
        .pop_i       (fifo_pop),
        .head_o      (fifo_head),
        .empty_o     (fifo_empty),
        .overflow_o  (fifo_overflow)
    );

    kbd_regs regs0 (
        .clk_i           (clk_i),
        .reset_i         (reset_i),
        .sel_i           (sel_i),
        .we_i            (we_i),
        .addr_i          (addr_i),
        .wdata_i         (wdata_i),
        .rdata_o         (rdata_o),
        .fifo_head_i     (fifo_head),
        .fifo_empty_i    (fifo_empty),
        .fifo_overflow_i (fifo_overflow),
        .rx_error_i      (rx_error),
        .fifo_pop_o      (fifo_pop),
        .enable_o        (ctrl_enable),
        .irq_o           (irq_o)
    );

endmodule

// File: tests/kbd_tb.sv
`timescale 1ns/10ps
`include "kbd_settings.svh"

module kbd_tb
    import ps2_pkg::*;
    import kbd_pkg::*;
();

    // PS/2 clock half period in system cycles
    localparam int HALF  = 20;
    localparam int LIMIT = 40 * 11 * 2 * HALF + 2000;

    logic       clk_i = 1'b0;
    logic       reset_i;
    logic       ps2_clk;
    logic       ps2_data;
    logic       sel_i;
    logic       we_i;
    reg_addr_t  addr_i;
    reg_data_t  wdata_i;
    reg_data_t  rdata_o;
    logic       irq_o;

    int         seed = 32'h95240c91;
    int         errors = 0;
    int         tests_ok = 0;
    int         tests_bad = 0;
    int         cycles = 0;
    logic       irq_en_tb = 1'b0;
    key_event_t expq[$];

    kbd_top dut0 (
        .clk_i      (clk_i),
        .reset_i    (reset_i),
        .ps2_clk_i  (ps2_clk),
        .ps2_data_i (ps2_data),
        .sel_i      (sel_i),
        .we_i       (we_i),
        .addr_i     (addr_i),
        .wdata_i    (wdata_i),
        .rdata_o    (rdata_o),
        .irq_o      (irq_o)
    );

    always #2 clk_i = ~clk_i;

    always @(posedge clk_i) begin
        cycles++;
        if (cycles == LIMIT) begin
            $display("timeout: run did not finish within %0d cycles", LIMIT);
            $display("*** FAILED ***");
            $finish;
        end
    end

    // interrupt only after irq_en was set in CTRL
    a_irq_enabled: assert property (
        @(posedge clk_i) disable iff (reset_i)
        irq_o |-> $past(irq_en_tb)
    ) else begin
        errors++;
        $display("[ERROR] %0t ns irq_o expected 0 got 1", $time);
    end

    task automatic wait_cycles(input int n);
        repeat (n) @(posedge clk_i);
        #1;
    endtask

    task automatic check_value(input string name, input reg_data_t got, input reg_data_t exp);
        a_value: assert (got === exp) else begin
            errors++;
            $display("[ERROR] %0t ns %s expected %h got %h", $time, name, exp, got);
        end
    endtask

    // data changes while the PS/2 clock is high
    task automatic ps2_bit(input logic b);
        ps2_data = b;
        wait_cycles(HALF);
        ps2_clk = 1'b0;
        wait_cycles(HALF);
        ps2_clk = 1'b1;
    endtask

    task automatic ps2_send(input byte_t b, input logic bad_parity, input logic bad_stop);
        ps2_bit(1'b0);
        for (int i = 0; i < 8; i++) begin
            ps2_bit(b[i]);
        end
        // odd parity
        ps2_bit(~^b ^ bad_parity);
        ps2_bit(~bad_stop);
        ps2_data = 1'b1;
        wait_cycles(2 * HALF);
    endtask

    task automatic reg_write(input reg_addr_t addr, input reg_data_t data);
        sel_i   = 1'b1;
        we_i    = 1'b1;
        addr_i  = addr;
        wdata_i = data;
        wait_cycles(1);
        sel_i = 1'b0;
        we_i  = 1'b0;
        if (addr == `KBD_ADDR_CTRL) begin
            irq_en_tb = data[1];
        end
    endtask

    // rdata_o is sampled mid-cycle before the popping edge
    task automatic reg_read(input reg_addr_t addr, output reg_data_t data);
        sel_i  = 1'b1;
        we_i   = 1'b0;
        addr_i = addr;
        #2;
        data = rdata_o;
        @(posedge clk_i);
        #1;
        sel_i = 1'b0;
    endtask

    function automatic byte_t random_code();
        byte_t b;
        b = $random(seed);
        while (b == 8'hE0 || b == 8'hF0) begin
            b = $random(seed);
        end
        return b;
    endfunction

    // prefixes first, then the final byte
    task automatic send_key(input logic ext, input logic rel, input byte_t code);
        if (ext) begin
            ps2_send(8'hE0, 1'b0, 1'b0);
        end
        if (rel) begin
            ps2_send(8'hF0, 1'b0, 1'b0);
        end
        ps2_send(code, 1'b0, 1'b0);
        expq.push_back({rel, ext, code});
    endtask

    task automatic wait_event();
        reg_data_t st;
        int        tries;
        st    = '0;
        tries = 0;
        while (!st[0] && tries < 20) begin
            reg_read(`KBD_ADDR_STATUS, st);
            tries++;
        end
        if (!st[0]) begin
            errors++;
            $display("no key event reached the FIFO after %0d status reads", tries);
        end
    endtask

    // drain DATA in order and check that irq follows irq_en while entries remain
    task automatic expect_events();
        reg_data_t  d;
        key_event_t e;
        while (expq.size() > 0) begin
            check_value("irq_o", irq_o, irq_en_tb);
            e = expq.pop_front();
            reg_read(`KBD_ADDR_DATA, d);
            check_value("DATA", d, reg_data_t'(e));
        end
    endtask

    task automatic finish_test(input int num, input string name, input int errs_before);
        if (errors == errs_before) begin
            tests_ok++;
            $display("test %0d %s: ok", num, name);
        end else begin
            tests_bad++;
            $display("test %0d %s: failed with %0d errors", num, name, errors - errs_before);
        end
    endtask

    initial begin
        reg_data_t d;
        int        e0;
        reset_i  = 1'b1;
        ps2_clk  = 1'b1;
        ps2_data = 1'b1;
        sel_i    = 1'b0;
        we_i     = 1'b0;
        addr_i   = '0;
        wdata_i  = '0;
        wait_cycles(2);
        reset_i = 1'b0;

        e0 = errors;
        reg_write(`KBD_ADDR_CTRL, 16'h0001);
        repeat (5) send_key(1'b0, 1'b0, random_code());
        wait_event();
        expect_events();
        reg_read(`KBD_ADDR_STATUS, d);
        check_value("STATUS.not_empty", d[0], 0);
        finish_test(1, "make codes", e0);

        e0 = errors;
        send_key(1'b0, 1'b1, random_code());
        send_key(1'b1, 1'b0, random_code());
        send_key(1'b1, 1'b1, random_code());
        wait_event();
        expect_events();
        reg_read(`KBD_ADDR_STATUS, d);
        check_value("STATUS.not_empty", d[0], 0);
        finish_test(2, "prefixes", e0);

        // no bad frame was sent before this test
        e0 = errors;
        reg_read(`KBD_ADDR_ERRCNT, d);
        check_value("ERRCNT", d, 16'd0);
        ps2_send(random_code(), 1'b1, 1'b0);
        reg_read(`KBD_ADDR_ERRCNT, d);
        check_value("ERRCNT", d, 16'd1);
        reg_read(`KBD_ADDR_STATUS, d);
        check_value("STATUS", d, 16'h0004);
        ps2_send(random_code(), 1'b0, 1'b1);
        reg_read(`KBD_ADDR_ERRCNT, d);
        check_value("ERRCNT", d, 16'd2);
        reg_write(`KBD_ADDR_STATUS, 16'h0004);
        reg_read(`KBD_ADDR_STATUS, d);
        check_value("STATUS", d, 16'h0000);
        send_key(1'b0, 1'b0, random_code());
        wait_event();
        expect_events();
        finish_test(3, "frame errors", e0);

        e0 = errors;
        reg_write(`KBD_ADDR_CTRL, 16'h0000);
        ps2_send(random_code(), 1'b0, 1'b0);
        reg_read(`KBD_ADDR_STATUS, d);
        check_value("STATUS.not_empty", d[0], 0);
        reg_write(`KBD_ADDR_CTRL, 16'h0001);
        send_key(1'b0, 1'b0, random_code());
        wait_event();
        expect_events();
        finish_test(4, "enable", e0);

        e0 = errors;
        reg_write(`KBD_ADDR_CTRL, 16'h0003);
        for (int i = 0; i < `KBD_FIFO_DEPTH; i++) begin
            send_key(1'b0, 1'b0, random_code());
        end
        // one more than fits is dropped
        ps2_send(random_code(), 1'b0, 1'b0);
        reg_read(`KBD_ADDR_STATUS, d);
        check_value("STATUS.overflow", d[1], 1);
        expect_events();
        wait_cycles(2);
        check_value("irq_o", irq_o, 0);
        finish_test(5, "overflow and interrupt", e0);

        $display("tests passed %0d, tests failed %0d, errors %0d", tests_ok, tests_bad, errors);
        if (errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

// File: vlog.f
+incdir+design
design/ps2_pkg.sv
design/kbd_pkg.sv
design/ps2_rx.sv
design/scancode_decoder.sv
design/key_fifo.sv
design/kbd_regs.sv
design/kbd_top.sv
tests/kbd_tb.sv
